//--- all.f
source/ctrlPkg.sv
source/aluDecoder.sv
source/controlFsm.sv
source/controlUnit.sv
sim/controlUnit_assertions.sv
sim/tb_controlUnit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the controlUnit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --assert --top-module tb_controlUnit \
        --Mdir obj_dir -o simControlUnit -f all.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simControlUnit > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TEST FAILED" "$logFile"; then
    exit 1
fi
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
exit 0

//--- sim/controlUnit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit_assertions (
    input logic              clk,
    input logic              rstn,
    input ctrlPkg::ctrlWordT ctrl,
    input logic              txStart,
    input ctrlPkg::stateT    state
);
    import ctrlPkg::*;

    // instruction register and register file never load together
    irWriteExclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(ctrl.irWrite && ctrl.regWrite))
        else $error("irWrite and regWrite high in the same cycle");

    storeUsesAluOut: assert property (@(posedge clk) disable iff (!rstn)
        ctrl.memWrite |-> ctrl.iorD)
        else $error("memWrite high without iorD");

    txStartPulse: assert property (@(posedge clk) disable iff (!rstn)
        txStart |=> !txStart)
        else $error("txStart held longer than one cycle");

    legalState: assert property (@(posedge clk) disable iff (!rstn)
        state <= sInDone) // 25 to 31 unused
        else $error("state outside its legal encodings");

endmodule

bind controlUnit controlUnit_assertions u_controlUnitAssertions (
    .clk     (clk),
    .rstn    (rstn),
    .ctrl    (ctrl),
    .txStart (txStart),
    .state   (state)
);

`default_nettype wire

//--- sim/tb_controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_controlUnit;
    import ctrlPkg::*;

    localparam int NUM_INSTR    = 400;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_CYCLES   = 7 + 7 + 1; // longest path, longest rx wait, one spare
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_INSTR * MAX_CYCLES) * 10;

    typedef struct packed {
        stateT    st;
        ctrlWordT cw;
    } stepT;

    logic        clk;
    logic        rstn;
    opcodeT      op;
    functT       funct;
    logic        rxReady;
    ctrlWordT    ctrl;
    aluCtrlT     aluCtrl;
    logic        shiftSel;
    logic        shiftDir;
    logic        txStart;
    stateT       state;

    stepT        expSteps[$]; // states after fetch for the current instruction
    logic [31:0] rng;
    int          errorCount;
    opcodeT      keptOps [14];
    functT       keptFuncts [9];
    opcodeT      illegalOps [4];

    controlUnit u_controlUnit (
        .clk      (clk),
        .rstn     (rstn),
        .op       (op),
        .funct    (funct),
        .rxReady  (rxReady),
        .ctrl     (ctrl),
        .aluCtrl  (aluCtrl),
        .shiftSel (shiftSel),
        .shiftDir (shiftDir),
        .txStart  (txStart),
        .state    (state)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic ctrlWordT withWrite(input ctrlWordT w, input regDstT dst,
                                           input memToRegT src);
        w.regWrite = 1'b1;
        w.regDst = dst;
        w.memToReg = src;
        return w;
    endfunction

    function automatic aluOpT classOf(input opcodeT o);
        case (o)
            opRType:      return aluOpByFunct;
            opBeq, opBne: return aluOpSub;
            opAndi:       return aluOpAnd;
            opOri:        return aluOpOr;
            opSlti:       return aluOpSlt;
            default:      return aluOpAdd;
        endcase
    endfunction

    function automatic aluCtrlT expAluCtrl(input aluOpT a, input functT f);
        if (a == aluOpByFunct) begin
            case (f)
                fnSub:   return aluCtrlSub;
                fnAnd:   return aluCtrlAnd;
                fnOr:    return aluCtrlOr;
                fnSlt:   return aluCtrlSlt;
                default: return aluCtrlAdd; // add, jr, jalr, shifts
            endcase
        end
        case (a)
            aluOpSub: return aluCtrlSub;
            aluOpAnd: return aluCtrlAnd;
            aluOpOr:  return aluCtrlOr;
            aluOpSlt: return aluCtrlSlt;
            default:  return aluCtrlAdd;
        endcase
    endfunction

    // fetch to fetch, per instruction class
    function automatic int tableCycles(input opcodeT o, input int rxDelay);
        case (o)
            opLw:                                          return 7;
            opRType, opSw, opLui, opAddi, opAndi, opOri, opSlti: return 5;
            opBeq, opBne, opJ, opJal:                      return 4;
            opOut:                                         return 6;
            opIn:                                          return 6 + rxDelay;
            default:                                       return 3;
        endcase
    endfunction

    function automatic void push(input stateT s, input ctrlWordT w);
        stepT e;
        e.st = s;
        e.cw = w;
        expSteps.push_back(e);
    endfunction

    // fields hold from the word seen in fetch unless a state changes them
    function automatic void buildSteps(input opcodeT o, input functT f, input int rxDelay,
                                       input ctrlWordT fetchWord);
        ctrlWordT w;
        expSteps.delete();
        w = fetchWord;
        w.pcWrite = 1'b0;
        w.irWrite = 1'b1;
        push(sFetchWait, w);
        w.irWrite = 1'b0;
        w.aluSrcB = aluSrcBShiftedImm; // branch target during decode
        push(sDecode, w);
        w.aluSrcA = 1'b1; // register A from here on
        w.aluOp = classOf(o);
        case (o)
            opLw: begin
                w.aluSrcB = aluSrcBSignImm;
                push(sMemAdr, w);
                w.iorD = 1'b1;
                push(sMemRead, w);
                push(sMemReadWait, w);
                push(sMemWriteback, withWrite(w, regDstRt, memToRegMemData));
            end
            opSw: begin
                w.aluSrcB = aluSrcBSignImm;
                push(sMemAdr, w);
                w.iorD = 1'b1;
                w.memWrite = 1'b1;
                push(sMemWrite, w);
            end
            opRType: begin
                w.aluSrcB = aluSrcBReg;
                w.pcWrite = (f == fnJr) || (f == fnJalr); // pc from rs
                if (f == fnJalr) begin
                    w = withWrite(w, regDstRa, memToRegPcLink);
                    push(sJumpLinkReg, w);
                    w.pcWrite = 1'b0;
                    w.regWrite = 1'b0; // routing stays, write is over
                    push(sAluWriteback, w);
                end else begin
                    push(sExecute, w);
                    w.pcWrite = 1'b0;
                    push(sAluWriteback, withWrite(w, regDstRd, memToRegAluOut));
                end
            end
            opLui: begin
                w.upperLoad = 1'b1;
                push(sLoadUi, w);
                w.upperLoad = 1'b0;
                push(sLuiWriteback, withWrite(w, regDstRt, memToRegAluOut));
            end
            opAddi, opAndi, opOri, opSlti: begin
                w.aluSrcB = aluSrcBSignImm;
                w.immZeroExt = (o == opAndi) || (o == opOri);
                push(sImmExecute, w);
                w.immZeroExt = 1'b0;
                push(sImmWriteback, withWrite(w, regDstRt, memToRegAluOut));
            end
            opBeq, opBne: begin
                w.aluSrcB = aluSrcBReg;
                w.branch = 1'b1;
                w.toggleEqual = (o == opBne);
                w.pcSrc = pcSrcAluOut;
                push((o == opBne) ? sBranchNe : sBranch, w);
            end
            opJ, opJal: begin
                w.pcWrite = 1'b1;
                w.pcSrc = pcSrcJumpTarget;
                if (o == opJal) begin
                    push(sJumpLink, withWrite(w, regDstRa, memToRegPcLink));
                end else begin
                    push(sJump, w);
                end
            end
            opOut: begin
                push(sOutPre, w);
                push(sOutWait, w);
                push(sOutDone, w);
            end
            opIn: begin
                repeat (rxDelay + 1) push(sInWait, w);
                push(sInPre, w);
                push(sInDone, withWrite(w, regDstRt, memToRegRxData));
            end
            default: ; // unknown opcode, straight back to fetch
        endcase
    endfunction

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("[FAIL] %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic checkCtrl(input ctrlWordT exp, input ctrlWordT got, input string where);
        if (got !== exp) reportFailure($sformatf("%s ctrl expected %h got %h", where, exp, got));
    endtask

    task automatic checkAluCtrl(input aluCtrlT exp, input aluCtrlT got, input string where);
        if (got !== exp) begin
            reportFailure($sformatf("%s aluCtrl expected %s got %s", where, exp.name(),
                                    got.name()));
        end
    endtask

    task automatic checkState(input stateT exp, input stateT got, input string where);
        if (got !== exp) begin
            reportFailure($sformatf("%s state expected %s got %s", where, exp.name(),
                                    got.name()));
        end
    endtask

    task automatic checkCount(input int exp, input int got, input string where);
        if (got != exp) reportFailure($sformatf("%s cycles expected %0d got %0d", where, exp, got));
    endtask

    task automatic checkFlag(input logic exp, input logic got, input string where);
        if (got !== exp) reportFailure($sformatf("%s expected %b got %b", where, exp, got));
    endtask

    initial begin
        int          n;
        int          pick;
        int          rxDelay;
        int          cycles;
        int          idx;
        int          inWaitSeen;
        logic [31:0] r;
        opcodeT      o;
        functT       f;
        stepT        e;
        string       tag;
        logic        firstFetch;

        rstn = 1'b0;
        op = opRType;
        funct = fnAdd;
        rxReady = 1'b0;
        rng = 32'h9cb2_e3eb;
        errorCount = 0;
        firstFetch = 1'b1;
        keptOps = '{opRType, opLw, opSw, opLui, opAddi, opAndi, opOri, opSlti,
                    opBeq, opBne, opJ, opJal, opIn, opOut};
        keptFuncts = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnJr, fnJalr, fnSll, fnSrl};
        // fp ops, flw, fsw and an unused code
        illegalOps = '{opcodeT'(6'b010001), opcodeT'(6'b110001), opcodeT'(6'b111001),
                       opcodeT'(6'b111111)};
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;

        for (n = 0; n < NUM_INSTR; n++) begin
            r = nextRand();
            pick = int'(r[15:8]) % 14;
            o = (r[4:0] == 5'd0) ? illegalOps[int'(r[9:8])] : keptOps[pick];
            f = keptFuncts[int'(r[23:16]) % 9];
            rxDelay = int'(r[26:24]);
            tag = $sformatf("instr %0d op %02h funct %s", n, o, f.name());
            buildSteps(o, f, rxDelay, firstFetch ? CTRL_RESET : CTRL_FETCH);

            checkState(sFetch, state, tag);
            checkCtrl(firstFetch ? CTRL_RESET : CTRL_FETCH, ctrl, tag);
            checkAluCtrl(aluCtrlAdd, aluCtrl, tag);
            checkFlag(1'b0, txStart, {tag, " txStart in fetch"});
            firstFetch = 1'b0;
            cycles = 1;
            idx = 0;
            inWaitSeen = 0;

            @(negedge clk);
            while (state != sFetch) begin
                cycles++;
                if (idx >= expSteps.size()) begin
                    reportFailure($sformatf("%s extra state %s", tag, state.name()));
                end
                e = expSteps[idx];
                checkState(e.st, state, tag);
                checkCtrl(e.cw, ctrl, tag);
                checkAluCtrl(expAluCtrl(e.cw.aluOp, funct), aluCtrl, tag);
                checkFlag((e.cw.aluOp == aluOpByFunct) && (funct == fnSll || funct == fnSrl),
                          shiftSel, {tag, " shiftSel"});
                checkFlag((e.cw.aluOp == aluOpByFunct) && (funct == fnSrl), shiftDir,
                          {tag, " shiftDir"});
                checkFlag(e.st == sOutWait, txStart, {tag, " txStart"});

                if (idx == 0) begin // instruction register loads in fetchWait
                    op = o;
                    funct = f;
                end
                if (e.st == sInWait) inWaitSeen++;
                r = nextRand();
                rxReady = (e.st == sInWait) ? (inWaitSeen == rxDelay + 1) : r[0];
                idx++;
                @(negedge clk);
            end
            checkCount(tableCycles(o, rxDelay), cycles, tag);
        end

        if (errorCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "checks failed");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the instruction stream finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- source/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
    input  ctrlPkg::aluOpT   aluOp,
    input  ctrlPkg::functT   funct,
    output ctrlPkg::aluCtrlT aluCtrl,
    output logic             shiftSel,
    output logic             shiftDir
);
    import ctrlPkg::*;

    logic byFunct;

    assign byFunct = (aluOp == aluOpByFunct);

    always_comb begin
        case (aluOp)
            aluOpAdd: aluCtrl = aluCtrlAdd;
            aluOpSub: aluCtrl = aluCtrlSub;
            aluOpAnd: aluCtrl = aluCtrlAnd;
            aluOpOr:  aluCtrl = aluCtrlOr;
            aluOpSlt: aluCtrl = aluCtrlSlt;
            aluOpByFunct: begin
                case (funct)
                    fnSub:   aluCtrl = aluCtrlSub;
                    fnAnd:   aluCtrl = aluCtrlAnd;
                    fnOr:    aluCtrl = aluCtrlOr;
                    fnSlt:   aluCtrl = aluCtrlSlt;
                    // add, jr, jalr and the shifts all pass through the adder
                    default: aluCtrl = aluCtrlAdd;
                endcase
            end
            default: aluCtrl = aluCtrlAdd;
        endcase
    end

    // shifter replaces the ALU result for sll / srl
    assign shiftSel = byFunct && ((funct == fnSll) || (funct == fnSrl));
    assign shiftDir = byFunct && (funct == fnSrl); // high = right

endmodule

`default_nettype wire

//--- source/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
    input  logic             clk,
    input  logic             rstn,
    input  ctrlPkg::opcodeT  op,
    input  ctrlPkg::functT   funct,
    input  logic             rxReady,
    output ctrlPkg::ctrlWordT ctrl,
    output logic             txStart,
    output ctrlPkg::stateT   state
);
    import ctrlPkg::*;

    stateT    stateNext;
    ctrlWordT ctrlQ;
    ctrlWordT ctrlNext;
    logic     jumpReg; // jr / jalr take the pc from rs this cycle

    always_comb begin
        stateNext = state;
        ctrlNext  = ctrlQ; // fields hold unless the transition touches them

        case (state)
            sFetch: begin
                stateNext        = sFetchWait;
                ctrlNext.pcWrite = 1'b0;
                ctrlNext.irWrite = 1'b1; // instruction valid at memory output
            end
            sFetchWait: begin
                stateNext        = sDecode;
                ctrlNext.irWrite = 1'b0;
                ctrlNext.aluSrcA = 1'b0;
                ctrlNext.aluSrcB = aluSrcBShiftedImm; // branch target in advance
                ctrlNext.aluOp   = aluOpAdd;
            end
            sDecode: begin
                ctrlNext.aluSrcA = 1'b1;
                case (op)
                    opLw, opSw: begin
                        stateNext        = sMemAdr;
                        ctrlNext.aluSrcB = aluSrcBSignImm;
                        ctrlNext.aluOp   = aluOpAdd;
                    end
                    opLui: begin
                        stateNext          = sLoadUi;
                        ctrlNext.aluSrcB   = aluSrcBShiftedImm;
                        ctrlNext.upperLoad = 1'b1;
                        ctrlNext.aluOp     = aluOpAdd;
                    end
                    opRType: begin
                        ctrlNext.aluSrcB = aluSrcBReg;
                        ctrlNext.aluOp   = aluOpByFunct;
                        if (funct == fnJalr) begin
                            // link written while the pc still holds pc + 4
                            stateNext         = sJumpLinkReg;
                            ctrlNext.regWrite = 1'b1;
                            ctrlNext.regDst   = regDstRa;
                            ctrlNext.memToReg = memToRegPcLink;
                        end else begin
                            stateNext = sExecute;
                        end
                    end
                    opBeq, opBne: begin
                        stateNext            = (op == opBne) ? sBranchNe : sBranch;
                        ctrlNext.aluSrcB     = aluSrcBReg;
                        ctrlNext.aluOp       = aluOpSub;
                        ctrlNext.pcSrc       = pcSrcAluOut;
                        ctrlNext.branch      = 1'b1;
                        ctrlNext.toggleEqual = (op == opBne);
                    end
                    opAddi, opAndi, opOri, opSlti: begin
                        stateNext           = sImmExecute;
                        ctrlNext.aluSrcB    = aluSrcBSignImm;
                        ctrlNext.immZeroExt = (op == opAndi) || (op == opOri);
                        case (op)
                            opAndi:  ctrlNext.aluOp = aluOpAnd;
                            opOri:   ctrlNext.aluOp = aluOpOr;
                            opSlti:  ctrlNext.aluOp = aluOpSlt;
                            default: ctrlNext.aluOp = aluOpAdd;
                        endcase
                    end
                    opJ: begin
                        stateNext        = sJump;
                        ctrlNext.pcSrc   = pcSrcJumpTarget;
                        ctrlNext.pcWrite = 1'b1;
                    end
                    opJal: begin
                        stateNext         = sJumpLink;
                        ctrlNext.pcSrc    = pcSrcJumpTarget;
                        ctrlNext.pcWrite  = 1'b1;
                        ctrlNext.regWrite = 1'b1;
                        ctrlNext.regDst   = regDstRa;
                        ctrlNext.memToReg = memToRegPcLink;
                    end
                    opOut: stateNext = sOutPre;
                    opIn:  stateNext = sInWait;
                    default: stateNext = sFetch; // unknown opcode, skip it
                endcase
            end
            sMemAdr: begin
                ctrlNext.iorD = 1'b1;
                if (op == opSw) begin
                    stateNext         = sMemWrite;
                    ctrlNext.memWrite = 1'b1;
                end else begin
                    stateNext = sMemRead;
                end
            end
            sMemRead: stateNext = sMemReadWait; // extra cycle for the memory read
            sMemReadWait: begin
                stateNext         = sMemWriteback;
                ctrlNext.regWrite = 1'b1;
                ctrlNext.regDst   = regDstRt;
                ctrlNext.memToReg = memToRegMemData;
            end
            sExecute: begin
                stateNext         = sAluWriteback;
                ctrlNext.regWrite = 1'b1;
                ctrlNext.regDst   = regDstRd;
                ctrlNext.memToReg = memToRegAluOut;
            end
            sJumpLinkReg: begin
                stateNext         = sAluWriteback;
                ctrlNext.regWrite = 1'b0; // link already written
            end
            sLoadUi: begin
                stateNext          = sLuiWriteback;
                ctrlNext.upperLoad = 1'b0;
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.regDst    = regDstRt;
                ctrlNext.memToReg  = memToRegAluOut;
            end
            sImmExecute: begin
                stateNext           = sImmWriteback;
                ctrlNext.immZeroExt = 1'b0;
                ctrlNext.regWrite   = 1'b1;
                ctrlNext.regDst     = regDstRt;
                ctrlNext.memToReg   = memToRegAluOut;
            end
            sOutPre:  stateNext = sOutWait;
            sOutWait: stateNext = sOutDone;
            sInWait: begin
                if (rxReady) begin
                    stateNext = sInPre;
                end
            end
            sInPre: begin
                stateNext         = sInDone;
                ctrlNext.regWrite = 1'b1;
                ctrlNext.regDst   = regDstRt;
                ctrlNext.memToReg = memToRegRxData;
            end
            // writebacks, branches, jumps and serial completions
            default: stateNext = sFetch;
        endcase

        // every path back to fetch restarts from the same word
        if (stateNext == sFetch) begin
            ctrlNext = CTRL_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= sFetch;
            ctrlQ   <= CTRL_RESET;
            txStart <= 1'b0;
        end else begin
            state   <= stateNext;
            ctrlQ   <= ctrlNext;
            txStart <= (stateNext == sOutWait); // one cycle pulse
        end
    end

    // jr/jalr need funct, so the pc write is decided in the state itself
    assign jumpReg = (op == opRType) &&
                     (((state == sExecute) && (funct == fnJr)) ||
                      ((state == sJumpLinkReg) && (funct == fnJalr)));

    always_comb begin
        ctrl = ctrlQ;
        ctrl.pcWrite = ctrlQ.pcWrite | jumpReg;
        if (jumpReg) begin
            ctrl.pcSrc = pcSrcAluResult; // rs + $0 from the ALU
        end
    end

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic              clk,
    input  logic              rstn,
    input  ctrlPkg::opcodeT   op,
    input  ctrlPkg::functT    funct,
    input  logic              rxReady,
    output ctrlPkg::ctrlWordT ctrl,
    output ctrlPkg::aluCtrlT  aluCtrl,
    output logic              shiftSel,
    output logic              shiftDir,
    output logic              txStart,
    output ctrlPkg::stateT    state
);

    // sequencing and registered control word
    controlFsm u_controlFsm (
        .clk     (clk),
        .rstn    (rstn),
        .op      (op),
        .funct   (funct),
        .rxReady (rxReady),
        .ctrl    (ctrl),
        .txStart (txStart),
        .state   (state)
    );

    aluDecoder u_aluDecoder (
        .aluOp    (ctrl.aluOp), // combinational, same cycle
        .funct    (funct),
        .aluCtrl  (aluCtrl),
        .shiftSel (shiftSel),
        .shiftDir (shiftDir)
    );

endmodule

`default_nettype wire

//--- source/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // primary opcodes, integer subset only
    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opJ     = 6'b000010,
        opJal   = 6'b000011,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opAddi  = 6'b001000,
        opSlti  = 6'b001010,
        opAndi  = 6'b001100,
        opOri   = 6'b001101,
        opLui   = 6'b001111,
        opIn    = 6'b011010, // serial receive
        opOut   = 6'b011011, // serial transmit
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    // R-type function field
    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnSlt  = 6'b101010
    } functT;

    typedef enum logic [4:0] {
        sFetch,
        sFetchWait,
        sDecode,
        sMemAdr,
        sMemRead,
        sMemReadWait,
        sMemWriteback,
        sMemWrite,
        sExecute,
        sAluWriteback,
        sLoadUi,
        sLuiWriteback,
        sImmExecute,
        sImmWriteback,
        sBranch,
        sBranchNe,
        sJump,
        sJumpLink,
        sJumpLinkReg,
        sOutPre,
        sOutWait,
        sOutDone,
        sInWait,
        sInPre,
        sInDone
    } stateT;

    // operation class handed to the ALU decoder
    typedef enum logic [2:0] {
        aluOpAdd     = 3'b000,
        aluOpSub     = 3'b001,
        aluOpAnd     = 3'b010,
        aluOpOr      = 3'b011,
        aluOpSlt     = 3'b100,
        aluOpByFunct = 3'b111 // look at funct
    } aluOpT;

    typedef enum logic [2:0] {
        aluCtrlAnd = 3'b000,
        aluCtrlOr  = 3'b001,
        aluCtrlAdd = 3'b010,
        aluCtrlSub = 3'b110,
        aluCtrlSlt = 3'b111
    } aluCtrlT;

    typedef enum logic [1:0] {
        pcSrcAluResult  = 2'b00, // straight from the ALU
        pcSrcAluOut     = 2'b01, // registered branch target
        pcSrcJumpTarget = 2'b10
    } pcSrcT;

    typedef enum logic [1:0] {
        regDstRt = 2'b00,
        regDstRd = 2'b01,
        regDstRa = 2'b10  // link register
    } regDstT;

    typedef enum logic [1:0] {
        memToRegAluOut  = 2'b00,
        memToRegMemData = 2'b01,
        memToRegPcLink  = 2'b10,
        memToRegRxData  = 2'b11
    } memToRegT;

    typedef enum logic [1:0] {
        aluSrcBReg        = 2'b00,
        aluSrcBFour       = 2'b01,
        aluSrcBSignImm    = 2'b10,
        aluSrcBShiftedImm = 2'b11
    } aluSrcBT;

    typedef struct packed {
        logic     iorD;       // memory address from ALUOut
        logic     memWrite;
        logic     irWrite;
        logic     pcWrite;
        logic     branch;
        logic     toggleEqual; // bne inverts the zero flag
        pcSrcT    pcSrc;
        logic     aluSrcA;    // 1 selects register A
        aluSrcBT  aluSrcB;
        logic     immZeroExt; // andi / ori
        logic     regWrite;
        regDstT   regDst;
        memToRegT memToReg;
        logic     upperLoad;  // lui shift
        aluOpT    aluOp;
    } ctrlWordT;

    localparam ctrlWordT CTRL_RESET = '{
        iorD: 1'b0, memWrite: 1'b0, irWrite: 1'b0, pcWrite: 1'b1,
        branch: 1'b0, toggleEqual: 1'b0, pcSrc: pcSrcAluResult,
        aluSrcA: 1'b0, aluSrcB: aluSrcBFour, immZeroExt: 1'b1,
        regWrite: 1'b0, regDst: regDstRt, memToReg: memToRegAluOut,
        upperLoad: 1'b0, aluOp: aluOpAdd
    };

    // pc + 4 with everything else idle
    localparam ctrlWordT CTRL_FETCH = '{
        iorD: 1'b0, memWrite: 1'b0, irWrite: 1'b0, pcWrite: 1'b1,
        branch: 1'b0, toggleEqual: 1'b0, pcSrc: pcSrcAluResult,
        aluSrcA: 1'b0, aluSrcB: aluSrcBFour, immZeroExt: 1'b0,
        regWrite: 1'b0, regDst: regDstRt, memToReg: memToRegAluOut,
        upperLoad: 1'b0, aluOp: aluOpAdd
    };

endpackage

`default_nettype wire
